//--- logic/ion_pkg.sv
package ion_pkg;

	localparam int PACKET_W = 110;
	localparam int SLOT_W   = 4;
	localparam int TIMER_W  = 16;

	typedef logic [SLOT_W-1:0]   slot_t;
	typedef logic [7:0]          level_t;
	typedef logic [7:0]          aux_t;
	typedef logic [15:0]         stamp_t;
	typedef logic [15:0]         tag_t;
	typedef logic [PACKET_W-1:0] packet_t;
	typedef logic [TIMER_W-1:0]  timer_t;

	// slots at and above this count replay as empty.
	localparam int unsigned RECORD_COUNT = 8;

	localparam logic [6:0]  SYNC_CODE   = 7'd77;
	localparam logic [7:0]  HEADER_CODE = 8'd255;
	localparam logic [7:0]  MARKER_A    = 8'd239;
	localparam logic [7:0]  MARKER_B    = 8'd17;
	localparam logic [5:0]  CHANNEL_ID  = 6'd1;
	localparam logic [23:0] SENSOR_ID   = 24'd4272433;

	// field offsets inside a packet, from bit 0 upward.
	localparam int SYNC_LSB     = 0;
	localparam int FLAG_BIT     = 7;
	localparam int HEADER_LSB   = 8;
	localparam int LEVEL_LSB    = 16;
	localparam int AUX_LSB      = 24;
	localparam int STAMP_LSB    = 32;
	localparam int MARKER_A_LSB = 48;
	localparam int MARKER_B_LSB = 56;
	localparam int TAG_LSB      = 64;
	localparam int CHANNEL_LSB  = 80;
	localparam int SENSOR_LSB   = 86;

	typedef enum logic [0:0]
	{
		IDLE  = 1'b0,
		FETCH = 1'b1
	} seq_state_t;

endpackage

//--- logic/sample_if.sv
interface sample_if import ion_pkg::*; ();

	logic   valid;  // one-cycle record strobe.
	logic   empty;  // slot holds no record.
	logic   flag;
	level_t level;
	aux_t   aux;
	stamp_t stamp;
	tag_t   tag;

	modport source
	(
		output valid,
		output empty,
		output flag,
		output level,
		output aux,
		output stamp,
		output tag
	);

	modport sink
	(
		input valid,
		input empty,
		input flag,
		input level,
		input aux,
		input stamp,
		input tag
	);

endinterface

//--- logic/sample_sequencer.sv
module sample_sequencer import ion_pkg::*; #(
	parameter timer_t TIMER_CAP = 16'haaaa
) (
	input  logic  clock,
	input  logic  resetn,
	output logic  fetch,
	output slot_t slot
);

	seq_state_t state;
	seq_state_t state_next;
	timer_t     timer;
	logic       timer_done;

	assign timer_done = (timer == TIMER_CAP);
	assign fetch      = (state == FETCH);

	always_comb
	begin
		case (state)
			IDLE:
			begin
				if (timer_done)
				begin
					state_next = FETCH;
				end
				else
				begin
					state_next = IDLE;
				end
			end
			FETCH:
			begin
				state_next = IDLE;  // single fetch cycle.
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	// counts idle cycles, CAP+1 of them per interval.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			timer <= '0;
		end
		else if (state == IDLE)
		begin
			timer <= timer + timer_t'(1);
		end
		else
		begin
			timer <= '0;
		end
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			slot <= '0;
		end
		else if (fetch)
		begin
			slot <= slot + slot_t'(1);  // wraps after 15.
		end
	end

endmodule

//--- logic/sample_table.sv
module sample_table import ion_pkg::*; (
	input  logic     clock,
	input  logic     resetn,
	input  logic     fetch,
	input  slot_t    slot,
	sample_if.source rec
);

	logic   hit;
	logic   lut_flag;
	level_t lut_level;
	aux_t   lut_aux;
	stamp_t lut_stamp;
	tag_t   lut_tag;

	assign hit = (32'(slot) < RECORD_COUNT);

	// recorded readings, indexed by the low slot bits.
	always_comb
	begin
		case (slot[2:0])
			3'd0:
			begin
				lut_flag  = 1'b0;
				lut_level = 8'd177;
				lut_aux   = 8'd100;
				lut_stamp = 16'd881;
				lut_tag   = 16'd56110;
			end
			3'd1:
			begin
				lut_flag  = 1'b1;
				lut_level = 8'd176;
				lut_aux   = 8'd100;
				lut_stamp = 16'd925;
				lut_tag   = 16'd3791;
			end
			3'd2:
			begin
				lut_flag  = 1'b0;
				lut_level = 8'd177;
				lut_aux   = 8'd100;
				lut_stamp = 16'd962;
				lut_tag   = 16'd63275;
			end
			3'd3:
			begin
				lut_flag  = 1'b1;
				lut_level = 8'd177;
				lut_aux   = 8'd100;
				lut_stamp = 16'd1011;
				lut_tag   = 16'd24574;
			end
			3'd4:
			begin
				lut_flag  = 1'b1;
				lut_level = 8'd185;
				lut_aux   = 8'd100;
				lut_stamp = 16'd1045;
				lut_tag   = 16'd40019;
			end
			3'd5:
			begin
				lut_flag  = 1'b1;
				lut_level = 8'd186;
				lut_aux   = 8'd100;
				lut_stamp = 16'd1094;
				lut_tag   = 16'd50527;
			end
			3'd6:
			begin
				lut_flag  = 1'b0;
				lut_level = 8'd177;
				lut_aux   = 8'd100;
				lut_stamp = 16'd1136;
				lut_tag   = 16'd60177;
			end
			default:
			begin
				lut_flag  = 1'b0;
				lut_level = 8'd178;
				lut_aux   = 8'd100;
				lut_stamp = 16'd1178;
				lut_tag   = 16'd47222;
			end
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			rec.valid <= 1'b0;
		end
		else
		begin
			rec.valid <= fetch;  // one cycle behind fetch.
		end
	end

	always_ff @(posedge clock)
	begin
		if (fetch)
		begin
			rec.empty <= ~hit;
			if (hit)
			begin
				rec.flag  <= lut_flag;
				rec.level <= lut_level;
				rec.aux   <= lut_aux;
				rec.stamp <= lut_stamp;
				rec.tag   <= lut_tag;
			end
			else
			begin
				rec.flag  <= 1'b0;  // unused slot.
				rec.level <= '0;
				rec.aux   <= '0;
				rec.stamp <= '0;
				rec.tag   <= '0;
			end
		end
	end

endmodule

//--- logic/packet_framer.sv
module packet_framer import ion_pkg::*; (
	input  logic    clock,
	input  logic    resetn,
	sample_if.sink  rec,
	output logic    ready,
	output packet_t data_out
);

	packet_t frame;

	// fixed fields around the recorded ones.
	always_comb
	begin
		frame = '0;
		if (!rec.empty)
		begin
			frame[SYNC_LSB +: $bits(SYNC_CODE)]       = SYNC_CODE;
			frame[FLAG_BIT]                           = rec.flag;
			frame[HEADER_LSB +: $bits(HEADER_CODE)]   = HEADER_CODE;
			frame[LEVEL_LSB +: $bits(level_t)]        = rec.level;
			frame[AUX_LSB +: $bits(aux_t)]            = rec.aux;
			frame[STAMP_LSB +: $bits(stamp_t)]        = rec.stamp;
			frame[MARKER_A_LSB +: $bits(MARKER_A)]    = MARKER_A;
			frame[MARKER_B_LSB +: $bits(MARKER_B)]    = MARKER_B;
			frame[TAG_LSB +: $bits(tag_t)]            = rec.tag;
			frame[CHANNEL_LSB +: $bits(CHANNEL_ID)]   = CHANNEL_ID;
			frame[SENSOR_LSB +: $bits(SENSOR_ID)]     = SENSOR_ID;
		end
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			ready    <= 1'b0;
			data_out <= '0;
		end
		else
		begin
			ready <= rec.valid;
			if (rec.valid)
			begin
				data_out <= frame;
			end
			else
			begin
				data_out <= '0;  // bus idles at zero.
			end
		end
	end

endmodule

//--- logic/ion_sensor.sv
module ion_sensor import ion_pkg::*; #(
	parameter timer_t TIMER_CAP = 16'haaaa
) (
	input  logic    clock,
	input  logic    resetn,
	output logic    ready,
	output packet_t data_out
);

	logic  fetch;
	slot_t slot;

	sample_if rec_if ();

	// interval timer and slot index.
	sample_sequencer #(
		.TIMER_CAP (TIMER_CAP)
	) sample_sequencer_i (
		.clock  (clock),
		.resetn (resetn),
		.fetch  (fetch),
		.slot   (slot)
	);

	sample_table sample_table_i (
		.clock  (clock),
		.resetn (resetn),
		.fetch  (fetch),
		.slot   (slot),
		.rec    (rec_if.source)
	);

	packet_framer packet_framer_i (
		.clock    (clock),
		.resetn   (resetn),
		.rec      (rec_if.sink),
		.ready    (ready),
		.data_out (data_out)
	);

endmodule

//--- verif/ion_sensor_asserts.sv
module ion_sensor_asserts import ion_pkg::*; (
	input logic    clock,
	input logic    resetn,
	input logic    ready,
	input packet_t data_out
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;  // failed assertions so far.

	// ready is a single-cycle pulse.
	single_pulse: assert property (
		@(posedge clock) disable iff (!resetn)
		ready |=> !ready
	)
	else
	begin
		failures++;
		$error("ready stayed high for two cycles in a row");
	end

	idle_zero: assert property (
		@(posedge clock)
		!ready |-> (data_out == '0)
	)
	else
	begin
		failures++;
		$error("data_out is not zero while ready is low");
	end

	reset_quiet: assert property (
		@(posedge clock)
		!resetn |-> !ready
	)
	else
	begin
		failures++;
		$error("ready is high while resetn is low");
	end

endmodule

//--- verif/ion_sensor_checker.sv
module ion_sensor_checker import ion_pkg::*; #(
	parameter int TIMER_CAP = 20
) (
	input  logic    clock,
	input  logic    resetn,
	input  logic    ready,
	input  packet_t data_out,
	output int      value_errors,
	output int      spacing_errors
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic   FLAGS  [8] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
	localparam level_t LEVELS [8] = '{8'd177, 8'd176, 8'd177, 8'd177,
		8'd185, 8'd186, 8'd177, 8'd178};
	localparam aux_t   AUXES  [8] = '{8'd100, 8'd100, 8'd100, 8'd100,
		8'd100, 8'd100, 8'd100, 8'd100};
	localparam stamp_t STAMPS [8] = '{16'd881, 16'd925, 16'd962, 16'd1011,
		16'd1045, 16'd1094, 16'd1136, 16'd1178};
	localparam tag_t   TAGS   [8] = '{16'd56110, 16'd3791, 16'd63275, 16'd24574,
		16'd40019, 16'd50527, 16'd60177, 16'd47222};

	int      value_errs = 0;
	int      spacing_errs = 0;
	int      gap = -1;  // rising edges since release or last pulse.
	int      limit;
	logic    first_pulse = 1'b1;
	slot_t   exp_slot = '0;
	packet_t expected;

	assign value_errors   = value_errs;
	assign spacing_errors = spacing_errs;

	// highest field first, sensor id down to sync.
	function automatic packet_t expected_packet(input slot_t s);
		if (32'(s) >= RECORD_COUNT)
		begin
			return '0;
		end
		return {SENSOR_ID, CHANNEL_ID, TAGS[s[2:0]], MARKER_B, MARKER_A, STAMPS[s[2:0]],
			AUXES[s[2:0]], LEVELS[s[2:0]], HEADER_CODE, FLAGS[s[2:0]], SYNC_CODE};
	endfunction

	always @(negedge clock)
	begin
		if (!resetn)
		begin
			exp_slot    = '0;
			gap         = -1;
			first_pulse = 1'b1;
			if (ready !== 1'b0)
			begin
				$display("Fail ready in reset: expected %h, got %h", 1'b0, ready);
				value_errs++;
			end
			if (data_out !== '0)
			begin
				$display("Fail data_out in reset: expected %h, got %h", packet_t'(0), data_out);
				value_errs++;
			end
		end
		else
		begin
			gap   = gap + 1;
			limit = first_pulse ? TIMER_CAP + 3 : TIMER_CAP + 2;
			if (ready)
			begin
				if (gap != limit)
				begin
					$display("ready came %0d cycles after the previous event instead of %0d",
						gap, limit);
					spacing_errs++;
				end
				expected = expected_packet(exp_slot);
				if (data_out !== expected)
				begin
					$display("Fail data_out slot %0d: expected %h, got %h",
						exp_slot, expected, data_out);
					value_errs++;
				end
				exp_slot    = exp_slot + slot_t'(1);  // wraps after 15.
				gap         = 0;
				first_pulse = 1'b0;
			end
			else
			begin
				if (data_out !== '0)
				begin
					$display("Fail data_out idle: expected %h, got %h", packet_t'(0), data_out);
					value_errs++;
				end
				if (gap >= limit)
				begin
					$display("no ready pulse within %0d cycles", limit);
					spacing_errs++;
					gap         = 0;
					first_pulse = 1'b0;
				end
			end
		end
	end

endmodule

//--- verif/ion_sensor_tb.sv
module ion_sensor_tb import ion_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CAP  = 20;
	localparam int ROWS = 3;

	logic        clock = 1'b0;
	logic        resetn;
	logic        ready;
	packet_t     data_out;
	int          value_errors;
	int          spacing_errors;
	int          assert_failures;
	int          timeouts = 0;
	int          total_pulses = 0;
	int          pulse_rows [ROWS];  // ready pulses to see before the next reset.
	int          offset_rows [ROWS];  // cycles after the last pulse before reset.
	int          extra;
	int          row;
	bit          ok;
	logic [31:0] lfsr_state;

	always #4 clock = ~clock;

	ion_sensor #(
		.TIMER_CAP (16'(CAP))
	) ion_sensor_i (
		.clock    (clock),
		.resetn   (resetn),
		.ready    (ready),
		.data_out (data_out)
	);

	ion_sensor_checker #(
		.TIMER_CAP (CAP)
	) checker_i (
		.clock          (clock),
		.resetn         (resetn),
		.ready          (ready),
		.data_out       (data_out),
		.value_errors   (value_errors),
		.spacing_errors (spacing_errors)
	);

	bind ion_sensor ion_sensor_asserts ion_sensor_asserts_i (
		.clock    (clock),
		.resetn   (resetn),
		.ready    (ready),
		.data_out (data_out)
	);

	assign assert_failures = ion_sensor_i.ion_sensor_asserts_i.failures;

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output int value);
		int i;
		value = 0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic wait_pulses(input int count, output bit done);
		int seen;
		int cycles;
		int limit;
		seen   = 0;
		cycles = 0;
		limit  = CAP + 3 + 8;
		done   = 1'b1;
		while (seen < count && done)
		begin
			@(negedge clock);
			cycles++;
			if (ready)
			begin
				seen++;
				total_pulses++;
				cycles = 0;
			end
			else if (cycles > limit)
			begin
				$display("timeout: no ready pulse within %0d cycles", limit);
				done = 1'b0;
			end
		end
	endtask

	initial
	begin
		resetn     <= 1'b0;
		lfsr_state = 32'h151deef2;
		pulse_rows[0]  = 20;  // covers the wrap.
		offset_rows[0] = 2;
		draw_bits(3, extra);
		pulse_rows[1] = 1 + extra;
		draw_bits(3, extra);
		offset_rows[1] = extra;
		pulse_rows[2]  = 18;
		offset_rows[2] = 0;
		for (row = 0; row < ROWS; row++)
		begin
			@(posedge clock);
			resetn <= 1'b0;
			repeat (2) @(posedge clock);
			resetn <= 1'b1;
			wait_pulses(pulse_rows[row], ok);
			if (!ok)
			begin
				timeouts++;
				break;
			end
			repeat (offset_rows[row]) @(posedge clock);
		end
		repeat (4) @(negedge clock);
		$display("pulses %0d, value errors %0d, spacing errors %0d, assertion failures %0d, %s",
			total_pulses, value_errors, spacing_errors, assert_failures,
			$sformatf("timeouts %0d", timeouts));
		if (value_errors == 0 && spacing_errors == 0 && assert_failures == 0
			&& timeouts == 0 && total_pulses > 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
logic/ion_pkg.sv
logic/sample_if.sv
logic/sample_sequencer.sv
logic/sample_table.sv
logic/packet_framer.sv
logic/ion_sensor.sv
verif/ion_sensor_asserts.sv
verif/ion_sensor_checker.sv
verif/ion_sensor_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ion_sensor_tb
RTL_TOP   ?= ion_sensor
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_TEXT ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
